/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int xlen      = 32;
    localparam int div_steps = 32;
    localparam int alu_op_w  = 12;

    // one-hot alu op bit positions
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // divider fsm states
    localparam logic [1:0] div_idle   = 2'd0;
    localparam logic [1:0] div_load   = 2'd1;
    localparam logic [1:0] div_run    = 2'd2;
    localparam logic [1:0] div_finish = 2'd3;

    typedef enum logic [3:0] {
        uop_alu,
        uop_mul_w,
        uop_mulh_w,
        uop_mulh_wu,
        uop_div_w,
        uop_mod_w,
        uop_div_wu,
        uop_mod_wu,
        uop_rdcnt_vl,
        uop_rdcnt_vh
    } unit_op_t;

    typedef enum logic [3:0] {
        mem_none,
        mem_ld_w,
        mem_ld_h,
        mem_ld_hu,
        mem_ld_b,
        mem_ld_bu,
        mem_st_w,
        mem_st_h,
        mem_st_b
    } mem_op_t;

endpackage

/* logic/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  logic [ex_pkg::alu_op_w-1:0] alu_op,
    input  logic [ex_pkg::xlen-1:0]     src1,
    input  logic [ex_pkg::xlen-1:0]     src2,
    output logic [ex_pkg::xlen-1:0]     result
);

    logic [ex_pkg::xlen-1:0] add_res;
    logic [ex_pkg::xlen-1:0] sub_res;
    logic [ex_pkg::xlen-1:0] sll_res;
    logic [ex_pkg::xlen-1:0] srl_res;
    logic [ex_pkg::xlen-1:0] sra_res;
    logic [4:0]              shamt;
    logic                    slt_res;
    logic                    sltu_res;

    assign add_res  = src1 + src2;
    assign sub_res  = src1 - src2;
    assign slt_res  = $signed(src1) < $signed(src2);
    assign sltu_res = src1 < src2;

    assign shamt   = src2[4:0]; // only low five bits count
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $signed(src1) >>> shamt;

    // and-or select, op is one-hot
    always_comb begin
        result = ({ex_pkg::xlen{alu_op[ex_pkg::alu_add]}} & add_res)
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_sub]}} & sub_res)
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_and]}} & (src1 & src2))
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_nor]}} & ~(src1 | src2))
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_or]}}  & (src1 | src2))
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_xor]}} & (src1 ^ src2))
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_sll]}} & sll_res)
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_srl]}} & srl_res)
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_sra]}} & sra_res)
               | ({ex_pkg::xlen{alu_op[ex_pkg::alu_lui]}} & src2); // imm already shifted
        if (alu_op[ex_pkg::alu_slt]) begin
            result[0] = result[0] | slt_res;
        end
        if (alu_op[ex_pkg::alu_sltu]) begin
            result[0] = result[0] | sltu_res;
        end
    end

endmodule

/* logic/radix2_divider.sv */
`timescale 1ns/1ps

module radix2_divider (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  logic                    abort,
    input  logic                    is_signed,
    input  logic [ex_pkg::xlen-1:0] dividend,
    input  logic [ex_pkg::xlen-1:0] divisor,
    output logic                    done,
    output logic [ex_pkg::xlen-1:0] quotient,
    output logic [ex_pkg::xlen-1:0] remainder
);

    localparam int cnt_w = $clog2(ex_pkg::div_steps);

    logic [1:0]              state;
    logic [cnt_w-1:0]        step_cnt;
    logic [ex_pkg::xlen-1:0] quo;
    logic [ex_pkg::xlen-1:0] rem;
    logic [ex_pkg::xlen-1:0] dvs;
    logic [ex_pkg::xlen-1:0] a_mag;
    logic [ex_pkg::xlen-1:0] b_mag;
    logic [ex_pkg::xlen:0]   shifted;
    logic [ex_pkg::xlen+1:0] diff;
    logic                    neg_q;
    logic                    neg_r;
    logic                    div_zero;

    assign a_mag = (is_signed && dividend[ex_pkg::xlen-1]) ? -dividend : dividend;
    assign b_mag = (is_signed && divisor[ex_pkg::xlen-1]) ? -divisor : divisor;

    assign shifted = {rem, quo[ex_pkg::xlen-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs}; // msb set means borrow

    assign done = (state == ex_pkg::div_finish);

    always_ff @(posedge clk) begin
        if (!resetn || abort) begin
            state    <= ex_pkg::div_idle;
            step_cnt <= '0;
        end else begin
            case (state)
                ex_pkg::div_idle: begin
                    step_cnt <= '0;
                    if (start) begin
                        state <= ex_pkg::div_load;
                    end
                end
                ex_pkg::div_load: begin
                    // first restoring step happens here
                    step_cnt <= step_cnt + 1'b1;
                    state    <= ex_pkg::div_run;
                end
                ex_pkg::div_run: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == cnt_w'(ex_pkg::div_steps - 1)) begin
                        state <= ex_pkg::div_finish;
                    end
                end
                default: state <= ex_pkg::div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ex_pkg::div_idle && start) begin
            quo      <= a_mag;
            dvs      <= b_mag;
            rem      <= '0;
            neg_q    <= is_signed & (dividend[ex_pkg::xlen-1] ^ divisor[ex_pkg::xlen-1]);
            neg_r    <= is_signed & dividend[ex_pkg::xlen-1];
            div_zero <= (divisor == '0);
        end else if (state == ex_pkg::div_load || state == ex_pkg::div_run) begin
            quo <= {quo[ex_pkg::xlen-2:0], ~diff[ex_pkg::xlen+1]};
            rem <= diff[ex_pkg::xlen+1] ? shifted[ex_pkg::xlen-1:0] : diff[ex_pkg::xlen-1:0];
        end else if (state == ex_pkg::div_finish) begin
            // min / -1 lands on 0x80000000 by itself
            quotient  <= div_zero ? '1 : (neg_q ? -quo : quo);
            remainder <= neg_r ? -rem : rem; // rem = |dividend| when divisor is zero
        end
    end

endmodule

/* logic/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  ex_pkg::mem_op_t         mem_op,
    input  logic [1:0]              addr_low,
    input  logic [ex_pkg::xlen-1:0] store_data,
    output logic [3:0]              byte_en,
    output logic [ex_pkg::xlen-1:0] wdata,
    output logic                    ale
);

    always_comb begin
        byte_en = 4'b0000;
        wdata   = store_data;
        ale     = 1'b0;
        case (mem_op)
            ex_pkg::mem_st_b: begin
                byte_en = 4'b0001 << addr_low;
                wdata   = {4{store_data[7:0]}};
            end
            ex_pkg::mem_st_h: begin
                byte_en = 4'b0011 << {addr_low[1], 1'b0};
                wdata   = {2{store_data[15:0]}};
                ale     = addr_low[0];
            end
            ex_pkg::mem_st_w: begin
                byte_en = 4'b1111;
                ale     = |addr_low;
            end
            ex_pkg::mem_ld_w: ale = |addr_low;
            ex_pkg::mem_ld_h, ex_pkg::mem_ld_hu: ale = addr_low[0];
            default: ; // byte loads never misalign
        endcase
    end

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        flush,
    input  logic                        in_valid,
    output logic                        in_allowin,
    input  logic [ex_pkg::xlen-1:0]     in_pc,
    input  logic [ex_pkg::alu_op_w-1:0] in_alu_op,
    input  ex_pkg::unit_op_t            in_unit_op,
    input  ex_pkg::mem_op_t             in_mem_op,
    input  logic [ex_pkg::xlen-1:0]     in_src1,
    input  logic [ex_pkg::xlen-1:0]     in_src2,
    input  logic [ex_pkg::xlen-1:0]     in_rkd_value,
    input  logic                        in_rf_we,
    input  logic [4:0]                  in_rf_waddr,
    input  logic                        ms_allowin,
    output logic                        out_valid,
    output logic [ex_pkg::xlen-1:0]     out_pc,
    output logic [ex_pkg::xlen-1:0]     out_result,
    output logic                        out_rf_we,
    output logic                        out_res_from_mem,
    output logic                        out_ale,
    output logic [4:0]                  out_rf_waddr,
    output logic                        data_sram_en,
    output logic [3:0]                  data_sram_we,
    output logic [ex_pkg::xlen-1:0]     data_sram_addr,
    output logic [ex_pkg::xlen-1:0]     data_sram_wdata,
    output logic [ex_pkg::alu_op_w-1:0] es_alu_op,
    output logic [ex_pkg::xlen-1:0]     es_src1,
    output logic [ex_pkg::xlen-1:0]     es_src2,
    output logic [ex_pkg::xlen-1:0]     es_rkd_value,
    output ex_pkg::mem_op_t             es_mem_op,
    output logic                        div_start,
    output logic                        div_abort,
    output logic                        div_signed,
    input  logic [ex_pkg::xlen-1:0]     alu_result,
    input  logic [ex_pkg::xlen-1:0]     div_quotient,
    input  logic [ex_pkg::xlen-1:0]     div_remainder,
    input  logic [3:0]                  st_byte_en,
    input  logic [ex_pkg::xlen-1:0]     st_wdata,
    input  logic                        div_done,
    input  logic                        st_ale
);

    ex_pkg::unit_op_t es_unit_op;
    logic             es_valid;
    logic             ready_go;
    logic             is_div;
    logic             is_load;
    logic             is_store;
    logic             mem_go;
    logic             div_issued;
    logic             div_finished;
    logic [63:0]      retired_cnt;
    logic [63:0]      uprod;
    logic signed [63:0] sprod;

    assign is_div = es_unit_op inside {ex_pkg::uop_div_w, ex_pkg::uop_mod_w,
                                       ex_pkg::uop_div_wu, ex_pkg::uop_mod_wu};
    assign is_load  = es_mem_op inside {ex_pkg::mem_ld_w, ex_pkg::mem_ld_h, ex_pkg::mem_ld_hu,
                                        ex_pkg::mem_ld_b, ex_pkg::mem_ld_bu};
    assign is_store = es_mem_op inside {ex_pkg::mem_st_w, ex_pkg::mem_st_h, ex_pkg::mem_st_b};

    assign ready_go   = is_div ? div_finished : 1'b1;
    assign in_allowin = ~es_valid | (ready_go & ms_allowin);
    assign out_valid  = es_valid & ready_go & ~flush;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            out_pc       <= in_pc;
            es_alu_op    <= in_alu_op;
            es_unit_op   <= in_unit_op;
            es_mem_op    <= in_mem_op;
            es_src1      <= in_src1;
            es_src2      <= in_src2;
            es_rkd_value <= in_rkd_value;
            out_rf_we    <= in_rf_we;
            out_rf_waddr <= in_rf_waddr;
        end
    end

    // one start per held division
    assign div_start  = es_valid & is_div & ~div_issued & ~flush;
    assign div_abort  = flush;
    assign div_signed = es_unit_op inside {ex_pkg::uop_div_w, ex_pkg::uop_mod_w};

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            div_issued   <= 1'b0;
            div_finished <= 1'b0;
        end else if (in_allowin) begin
            div_issued   <= 1'b0;
            div_finished <= 1'b0;
        end else begin
            if (div_start) begin
                div_issued <= 1'b1;
            end
            if (div_done && div_issued) begin
                div_finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            retired_cnt <= 64'd0;
        end else if (out_valid && ms_allowin) begin
            retired_cnt <= retired_cnt + 64'd1; // counts downstream transfers
        end
    end

    assign uprod = es_src1 * es_src2;
    assign sprod = $signed(es_src1) * $signed(es_src2);

    always_comb begin
        case (es_unit_op)
            ex_pkg::uop_mul_w:    out_result = sprod[31:0];
            ex_pkg::uop_mulh_w:   out_result = sprod[63:32];
            ex_pkg::uop_mulh_wu:  out_result = uprod[63:32];
            ex_pkg::uop_div_w,
            ex_pkg::uop_div_wu:   out_result = div_quotient;
            ex_pkg::uop_mod_w,
            ex_pkg::uop_mod_wu:   out_result = div_remainder;
            ex_pkg::uop_rdcnt_vl: out_result = retired_cnt[31:0];
            ex_pkg::uop_rdcnt_vh: out_result = retired_cnt[63:32];
            default:              out_result = alu_result; // loads carry the address
        endcase
    end

    assign out_res_from_mem = is_load;
    assign out_ale          = es_valid & st_ale;

    assign mem_go          = es_valid & (es_mem_op != ex_pkg::mem_none) & ~st_ale & ~flush;
    assign data_sram_en    = mem_go;
    assign data_sram_we    = st_byte_en & {4{mem_go & is_store}};
    assign data_sram_addr  = {alu_result[ex_pkg::xlen-1:2], 2'b00};
    assign data_sram_wdata = st_wdata;

endmodule

/* logic/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        flush,
    input  logic                        in_valid,
    output logic                        in_allowin,
    input  logic [ex_pkg::xlen-1:0]     in_pc,
    input  logic [ex_pkg::alu_op_w-1:0] in_alu_op,
    input  ex_pkg::unit_op_t            in_unit_op,
    input  ex_pkg::mem_op_t             in_mem_op,
    input  logic [ex_pkg::xlen-1:0]     in_src1,
    input  logic [ex_pkg::xlen-1:0]     in_src2,
    input  logic [ex_pkg::xlen-1:0]     in_rkd_value,
    input  logic                        in_rf_we,
    input  logic [4:0]                  in_rf_waddr,
    input  logic                        ms_allowin,
    output logic                        out_valid,
    output logic [ex_pkg::xlen-1:0]     out_pc,
    output logic [ex_pkg::xlen-1:0]     out_result,
    output logic                        out_rf_we,
    output logic                        out_res_from_mem,
    output logic                        out_ale,
    output logic [4:0]                  out_rf_waddr,
    output logic                        data_sram_en,
    output logic [3:0]                  data_sram_we,
    output logic [ex_pkg::xlen-1:0]     data_sram_addr,
    output logic [ex_pkg::xlen-1:0]     data_sram_wdata
);

    logic [ex_pkg::alu_op_w-1:0] es_alu_op;
    logic [ex_pkg::xlen-1:0]     es_src1;
    logic [ex_pkg::xlen-1:0]     es_src2;
    logic [ex_pkg::xlen-1:0]     es_rkd_value;
    ex_pkg::mem_op_t             es_mem_op;
    logic                        div_start;
    logic                        div_abort;
    logic                        div_signed;
    logic                        div_done;
    logic [ex_pkg::xlen-1:0]     alu_result;
    logic [ex_pkg::xlen-1:0]     div_quotient;
    logic [ex_pkg::xlen-1:0]     div_remainder;
    logic [3:0]                  st_byte_en;
    logic [ex_pkg::xlen-1:0]     st_wdata;
    logic                        st_ale;

    ex_stage u_stage (.*); // port names match the wires one to one

    ex_alu u_alu (
        .alu_op (es_alu_op),
        .src1   (es_src1),
        .src2   (es_src2),
        .result (alu_result)
    );

    radix2_divider u_div (
        .clk       (clk),
        .resetn    (resetn),
        .start     (div_start),
        .abort     (div_abort),
        .is_signed (div_signed),
        .dividend  (es_src1),
        .divisor   (es_src2),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

    store_align u_store (
        .mem_op     (es_mem_op),
        .addr_low   (alu_result[1:0]),
        .store_data (es_rkd_value),
        .byte_en    (st_byte_en),
        .wdata      (st_wdata),
        .ale        (st_ale)
    );

endmodule

/* bench/ex_tb_cases.svh */
// columns: pc, alu op, unit op, mem op, src1, src2, rkd, rf_we, waddr, kind,
// result, {res_from_mem, ale, sram_en}, sram byte enables, sram wdata
function automatic void fill_cases();
    add_case(32'h1c000000, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'd5, 32'd7, 32'h0, 1'b1, 5'd1, 2'd0, 32'd12, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000004, op(ex_pkg::alu_sub), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'd3, 32'd5, 32'h0, 1'b1, 5'd2, 2'd0, 32'hfffffffe, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000008, op(ex_pkg::alu_slt), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'hffffffff, 32'd1, 32'h0, 1'b1, 5'd3, 2'd0, 32'd1, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c00000c, op(ex_pkg::alu_sltu), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'hffffffff, 32'd1, 32'h0, 1'b1, 5'd4, 2'd0, 32'd0, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000010, op(ex_pkg::alu_nor), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'h0f0f0000, 32'h00ff00ff, 32'h0, 1'b1, 5'd5, 2'd0, 32'hf000ff00, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000014, op(ex_pkg::alu_xor), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'ha5a5a5a5, 32'hffff0000, 32'h0, 1'b1, 5'd6, 2'd0, 32'h5a5aa5a5, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000018, op(ex_pkg::alu_sra), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'h80000000, 32'h24, 32'h0, 1'b1, 5'd7, 2'd0, 32'hf8000000, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c00001c, op(ex_pkg::alu_lui), ex_pkg::uop_alu, ex_pkg::mem_none,
        32'h0, 32'h12345000, 32'h0, 1'b1, 5'd8, 2'd0, 32'h12345000, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000020, op(ex_pkg::alu_add), ex_pkg::uop_rdcnt_vl, ex_pkg::mem_none,
        32'h0, 32'h0, 32'h0, 1'b1, 5'd9, 2'd1, 32'h0, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000024, op(ex_pkg::alu_add), ex_pkg::uop_rdcnt_vh, ex_pkg::mem_none,
        32'h0, 32'h0, 32'h0, 1'b1, 5'd10, 2'd0, 32'h0, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000028, op(ex_pkg::alu_add), ex_pkg::uop_mul_w, ex_pkg::mem_none,
        32'hfffffffe, 32'd3, 32'h0, 1'b1, 5'd11, 2'd0, 32'hfffffffa, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c00002c, op(ex_pkg::alu_add), ex_pkg::uop_mulh_w, ex_pkg::mem_none,
        32'hfffffffe, 32'd3, 32'h0, 1'b1, 5'd12, 2'd0, 32'hffffffff, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000030, op(ex_pkg::alu_add), ex_pkg::uop_mulh_wu, ex_pkg::mem_none,
        32'hfffffffe, 32'd3, 32'h0, 1'b1, 5'd13, 2'd0, 32'd2, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000034, op(ex_pkg::alu_add), ex_pkg::uop_div_w, ex_pkg::mem_none,
        32'hfffffff9, 32'd2, 32'h0, 1'b1, 5'd14, 2'd0, 32'hfffffffd, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000038, op(ex_pkg::alu_add), ex_pkg::uop_mod_w, ex_pkg::mem_none,
        32'hfffffff9, 32'd2, 32'h0, 1'b1, 5'd15, 2'd0, 32'hffffffff, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c00003c, op(ex_pkg::alu_add), ex_pkg::uop_div_wu, ex_pkg::mem_none,
        32'hfffffff9, 32'd2, 32'h0, 1'b1, 5'd16, 2'd0, 32'h7ffffffc, 3'b000, 4'h0, 32'h0);
    // division by zero
    add_case(32'h1c000040, op(ex_pkg::alu_add), ex_pkg::uop_div_w, ex_pkg::mem_none,
        32'd25, 32'd0, 32'h0, 1'b1, 5'd17, 2'd0, 32'hffffffff, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000044, op(ex_pkg::alu_add), ex_pkg::uop_mod_w, ex_pkg::mem_none,
        32'hfffffff9, 32'd0, 32'h0, 1'b1, 5'd18, 2'd0, 32'hfffffff9, 3'b000, 4'h0, 32'h0);
    // most negative over minus one
    add_case(32'h1c000048, op(ex_pkg::alu_add), ex_pkg::uop_div_w, ex_pkg::mem_none,
        32'h80000000, 32'hffffffff, 32'h0, 1'b1, 5'd19, 2'd0, 32'h80000000, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c00004c, op(ex_pkg::alu_add), ex_pkg::uop_mod_w, ex_pkg::mem_none,
        32'h80000000, 32'hffffffff, 32'h0, 1'b1, 5'd20, 2'd0, 32'h0, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000050, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_st_w,
        32'h1000, 32'd4, 32'h11223344, 1'b0, 5'd0, 2'd0, 32'h1004, 3'b001, 4'hf, 32'h11223344);
    add_case(32'h1c000054, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_st_h,
        32'h1000, 32'd2, 32'h11223344, 1'b0, 5'd0, 2'd0, 32'h1002, 3'b001, 4'hc, 32'h33443344);
    add_case(32'h1c000058, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_st_b,
        32'h1000, 32'd3, 32'h11223344, 1'b0, 5'd0, 2'd0, 32'h1003, 3'b001, 4'h8, 32'h44444444);
    add_case(32'h1c00005c, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_ld_w,
        32'h2000, 32'd8, 32'h0, 1'b1, 5'd21, 2'd0, 32'h2008, 3'b101, 4'h0, 32'h0);
    add_case(32'h1c000060, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_ld_b,
        32'h2000, 32'd3, 32'h0, 1'b1, 5'd22, 2'd0, 32'h2003, 3'b101, 4'h0, 32'h0);
    // misaligned accesses
    add_case(32'h1c000064, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_st_w,
        32'h1000, 32'd2, 32'h11223344, 1'b0, 5'd0, 2'd0, 32'h1002, 3'b010, 4'h0, 32'h0);
    add_case(32'h1c000068, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_st_h,
        32'h1000, 32'd1, 32'h11223344, 1'b0, 5'd0, 2'd0, 32'h1001, 3'b010, 4'h0, 32'h0);
    add_case(32'h1c00006c, op(ex_pkg::alu_add), ex_pkg::uop_alu, ex_pkg::mem_ld_h,
        32'h2000, 32'd3, 32'h0, 1'b1, 5'd23, 2'd0, 32'h2003, 3'b110, 4'h0, 32'h0);
    add_case(32'h1c000070, op(ex_pkg::alu_add), ex_pkg::uop_div_w, ex_pkg::mem_none,
        32'd100, 32'd7, 32'h0, 1'b1, 5'd24, 2'd2, 32'd14, 3'b000, 4'h0, 32'h0);
    // operands differ from the killed division so a stale result shows
    add_case(32'h1c000074, op(ex_pkg::alu_add), ex_pkg::uop_mod_wu, ex_pkg::mem_none,
        32'd100, 32'd9, 32'h0, 1'b1, 5'd25, 2'd0, 32'd1, 3'b000, 4'h0, 32'h0);
    add_case(32'h1c000078, op(ex_pkg::alu_add), ex_pkg::uop_rdcnt_vl, ex_pkg::mem_none,
        32'h0, 32'h0, 32'h0, 1'b1, 5'd26, 2'd1, 32'h0, 3'b000, 4'h0, 32'h0);
endfunction

/* bench/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb;

    typedef struct packed {
        logic [31:0]       pc;
        logic [11:0]       alu_op;
        ex_pkg::unit_op_t  uop;
        ex_pkg::mem_op_t   mop;
        logic [31:0]       src1;
        logic [31:0]       src2;
        logic [31:0]       rkd;
        logic              rf_we;
        logic [4:0]        waddr;
        logic [1:0]        kind;      // 0 plain, 1 rdcnt low word, 2 flushed division
        logic [31:0]       exp_result;
        logic [2:0]        exp_flags; // res_from_mem, ale, sram_en
        logic [3:0]        exp_we;
        logic [31:0]       exp_wdata;
    } case_t;

    logic             clk = 1'b0;
    logic             resetn;
    logic             flush;
    logic             in_valid;
    logic             in_allowin;
    logic [31:0]      in_pc;
    logic [11:0]      in_alu_op;
    ex_pkg::unit_op_t in_unit_op;
    ex_pkg::mem_op_t  in_mem_op;
    logic [31:0]      in_src1;
    logic [31:0]      in_src2;
    logic [31:0]      in_rkd_value;
    logic             in_rf_we;
    logic [4:0]       in_rf_waddr;
    logic             ms_allowin;
    logic             out_valid;
    logic [31:0]      out_pc;
    logic [31:0]      out_result;
    logic             out_rf_we;
    logic             out_res_from_mem;
    logic             out_ale;
    logic [4:0]       out_rf_waddr;
    logic             data_sram_en;
    logic [3:0]       data_sram_we;
    logic [31:0]      data_sram_addr;
    logic [31:0]      data_sram_wdata;

    case_t cases[$];
    int    errors = 0;
    int    checks = 0;
    int    timeouts = 0;
    int    retired = 0; // rows seen leaving the stage
    int    seed = 32'h63a7c739;

    always #5 clk = ~clk;

    ex_top DUT (.*);

    function automatic logic [11:0] op(int pos);
        return 12'b1 << pos;
    endfunction

    function automatic void add_case(logic [31:0] pc, logic [11:0] alu, ex_pkg::unit_op_t uop,
                                     ex_pkg::mem_op_t mop, logic [31:0] s1, logic [31:0] s2,
                                     logic [31:0] rkd, logic we, logic [4:0] wa,
                                     logic [1:0] kind, logic [31:0] res, logic [2:0] flags,
                                     logic [3:0] bwe, logic [31:0] wd);
        cases.push_back(case_t'{pc, alu, uop, mop, s1, s2, rkd, we, wa, kind, res, flags,
                                bwe, wd});
    endfunction

    `include "ex_tb_cases.svh"

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic send(case_t c);
        int   waited;
        logic took;
        in_valid     = 1'b1;
        in_pc        = c.pc;
        in_alu_op    = c.alu_op;
        in_unit_op   = c.uop;
        in_mem_op    = c.mop;
        in_src1      = c.src1;
        in_src2      = c.src2;
        in_rkd_value = c.rkd;
        in_rf_we     = c.rf_we;
        in_rf_waddr  = c.waddr;
        took   = 1'b0;
        waited = 0;
        while (!took && waited < 50) begin
            #1;
            if (out_valid) begin
                errors++;
                $display("Fail %0t: out_valid high before pc %h was accepted", $time, c.pc);
            end
            took = in_allowin; // transfer at the coming rising edge
            @(negedge clk);
            waited++;
        end
        in_valid = 1'b0;
        if (!took) begin
            timeouts++;
            $display("timeout: stage never accepted pc %h", c.pc);
        end
    endtask

    task automatic collect(case_t c);
        logic [31:0] exp;
        logic [31:0] held;
        logic        was_held;
        logic        got;
        int          waited;
        exp      = (c.kind == 2'd1) ? 32'(retired) : c.exp_result;
        held     = '0;
        was_held = 1'b0;
        got      = 1'b0;
        waited   = 0;
        while (!got && waited < 100) begin
            ms_allowin = ($random(seed) & 3) != 0;
            #1;
            if (out_valid) begin
                if (was_held && out_result !== held) begin
                    errors++;
                    $display("Fail %0t: result changed while ms_allowin was low", $time);
                end
                check("result", out_result, exp);
                check("pc", out_pc, c.pc);
                check("rf_we/rf_waddr", 32'({out_rf_we, out_rf_waddr}), 32'({c.rf_we, c.waddr}));
                check("res_from_mem/ale/sram_en",
                      32'({out_res_from_mem, out_ale, data_sram_en}), 32'(c.exp_flags));
                check("data_sram_we", 32'(data_sram_we), 32'(c.exp_we));
                if (c.exp_flags[0]) begin
                    check("data_sram_addr", data_sram_addr, {c.exp_result[31:2], 2'b00});
                end
                if (c.exp_we != 4'h0) begin
                    check("data_sram_wdata", data_sram_wdata, c.exp_wdata);
                end
                held     = out_result;
                was_held = !ms_allowin;
                got      = ms_allowin;
                if (ms_allowin) begin
                    retired++;
                end
            end
            waited++;
            @(negedge clk);
        end
        if (!got) begin
            timeouts++;
            $display("timeout: pc %h never left the stage", c.pc);
        end
    endtask

    // division killed shortly after issue and the next row sent while it would still run
    task automatic flush_row(case_t c);
        send(c);
        for (int i = 0; i < 6; i++) begin
            ms_allowin = ($random(seed) & 3) != 0;
            flush      = (i == 3);
            #1;
            check("out_valid around flush", 32'(out_valid), 32'd0);
            @(negedge clk);
        end
        flush = 1'b0;
    endtask

    initial begin
        resetn       = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_pc        = '0;
        in_alu_op    = '0;
        in_unit_op   = ex_pkg::uop_alu;
        in_mem_op    = ex_pkg::mem_none;
        in_src1      = '0;
        in_src2      = '0;
        in_rkd_value = '0;
        in_rf_we     = 1'b0;
        in_rf_waddr  = '0;
        ms_allowin   = 1'b1;
        fill_cases();
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        #1;
        check("out_valid after reset", 32'(out_valid), 32'd0);
        @(negedge clk);
        for (int i = 0; i < cases.size() && timeouts == 0; i++) begin
            if (cases[i].kind == 2'd2) begin
                flush_row(cases[i]);
            end else begin
                send(cases[i]);
                if (timeouts == 0) begin
                    collect(cases[i]);
                end
            end
        end
        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+bench
logic/ex_pkg.sv
logic/ex_alu.sv
logic/radix2_divider.sv
logic/store_align.sv
logic/ex_stage.sv
logic/ex_top.sv
bench/ex_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module ex_tb -o ex_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out="$(./obj_dir/ex_sim)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -Fqx "=== PASS ==="; then
    exit 0
fi
exit 1
